/* verilog/ecl_pkg.sv */
package ecl_pkg;

   //////////////////////////////////////////////////
   // data path
   //////////////////////////////////////////////////

   localparam int GRLEN = 32;

   // execution unit class, anything else decodes as illegal
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_LSU = 2'd1,
      UNIT_ILL = 2'd2
   } unit_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5
   } alu_op_e;

   typedef enum logic {
      LSU_LD_W = 1'b0,
      LSU_ST_W = 1'b1
   } lsu_op_e;

   //////////////////////////////////////////////////
   // stage bundles
   //////////////////////////////////////////////////

   // decoded instruction from fetch
   typedef struct packed {
      logic             valid;
      unit_e            unit;
      alu_op_e          alu_op;
      lsu_op_e          lsu_op;
      logic [31:0]      inst;
      logic [GRLEN-1:0] pc;
      logic [GRLEN-1:0] imm;
      logic             use_pc;
      logic             use_imm;
      logic             rf_wen;
   } issue_s;

   // instruction sitting in execute
   typedef struct packed {
      logic             alu_valid;
      logic             lsu_valid;
      alu_op_e          alu_op;
      lsu_op_e          lsu_op;
      logic [4:0]       rs1;
      logic [4:0]       rs2;
      logic [4:0]       rd;
      logic             rf_wen;
      logic [GRLEN-1:0] pc;
      logic [GRLEN-1:0] imm;
      logic             use_pc;
      logic             use_imm;
   } ex_s;

   typedef struct packed {
      logic             valid;
      lsu_op_e          op;
      logic [GRLEN-1:0] base;
      logic [GRLEN-1:0] offset;
      logic [GRLEN-1:0] wdata;
      logic [4:0]       rd;
      logic             wen;
   } lsu_req_s;

   typedef struct packed {
      logic             finish;
      logic [4:0]       rd;
      logic             wen;
      logic [GRLEN-1:0] rdata;
   } lsu_resp_s;

   // one register file write
   typedef struct packed {
      logic             wen;
      logic [4:0]       rd;
      logic [GRLEN-1:0] data;
   } wb_s;

endpackage

/* verilog/ecl_issue.sv */
`timescale 1ns/1ps

module ecl_issue (
   input  logic            clk,
   input  logic            rst_n,
   input  ecl_pkg::issue_s issue,
   input  logic            stall_req,
   output logic [4:0]      rs1_d,
   output logic [4:0]      rs2_d,
   output ecl_pkg::ex_s    ex,
   output logic            except
);

   logic         accept_d;
   logic         alu_disp_d;
   logic         lsu_disp_d;
   logic         ill_disp_d;
   logic         store_d;
   logic [4:0]   rj_d;
   logic [4:0]   rk_d;
   logic [4:0]   rd_d;
   ecl_pkg::ex_s ex_d;
   ecl_pkg::ex_s ex_q;
   logic         ill_q;

   //////////////////////////////////////////////////
   // register addresses
   //////////////////////////////////////////////////

   assign rd_d = issue.inst[4:0];
   assign rj_d = issue.inst[9:5];
   assign rk_d = issue.inst[14:10];

   assign store_d = (issue.unit == ecl_pkg::UNIT_LSU) && (issue.lsu_op == ecl_pkg::LSU_ST_W);

   // store data sits in rd
   assign rs1_d = rj_d;
   assign rs2_d = store_d ? rd_d : rk_d;

   //////////////////////////////////////////////////
   // accept and dispatch
   //////////////////////////////////////////////////

   // the cycle of except kills whatever is presented
   assign accept_d = issue.valid && !stall_req && !except;

   assign alu_disp_d = accept_d && (issue.unit == ecl_pkg::UNIT_ALU);
   assign lsu_disp_d = accept_d && (issue.unit == ecl_pkg::UNIT_LSU);
   // unknown unit codes are treated as illegal too
   assign ill_disp_d = accept_d && !alu_disp_d && !lsu_disp_d;

   always_comb begin
      ex_d           = '0;
      ex_d.alu_valid = alu_disp_d;
      ex_d.lsu_valid = lsu_disp_d;
      ex_d.alu_op    = issue.alu_op;
      ex_d.lsu_op    = issue.lsu_op;
      ex_d.rs1       = rs1_d;
      ex_d.rs2       = rs2_d;
      ex_d.rd        = rd_d;
      ex_d.rf_wen    = issue.rf_wen;
      ex_d.pc        = issue.pc;
      ex_d.imm       = issue.imm;
      ex_d.use_pc    = issue.use_pc;
      ex_d.use_imm   = issue.use_imm;
   end

   //////////////////////////////////////////////////
   // decode to execute
   //////////////////////////////////////////////////

   // bubble when both valids are low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_q  <= '0;
         ill_q <= 1'b0;
      end else begin
         ex_q  <= ex_d;
         ill_q <= ill_disp_d;
      end
   end

   assign ex = ex_q;

   // one cycle pulse after an illegal instruction
   assign except = ill_q;

endmodule

/* verilog/ecl_bypass.sv */
`timescale 1ns/1ps

module ecl_bypass (
   input  ecl_pkg::ex_s                ex,
   input  logic [ecl_pkg::GRLEN-1:0]   rs1_data_e,
   input  logic [ecl_pkg::GRLEN-1:0]   rs2_data_e,
   input  ecl_pkg::wb_s                wb_m,
   input  ecl_pkg::wb_s                wb_w,
   output logic [ecl_pkg::GRLEN-1:0]   opa_e,
   output logic [ecl_pkg::GRLEN-1:0]   opb_e,
   output logic [ecl_pkg::GRLEN-1:0]   alu_a_e,
   output logic [ecl_pkg::GRLEN-1:0]   alu_b_e
);

   // youngest write wins, memory stage first
   function automatic logic [ecl_pkg::GRLEN-1:0] fwd(
      input logic [4:0]                rs,
      input logic [ecl_pkg::GRLEN-1:0] rf_data,
      input ecl_pkg::wb_s              m,
      input ecl_pkg::wb_s              w
   );
      logic [ecl_pkg::GRLEN-1:0] val;
      if (m.wen && (m.rd == rs)) begin
         val = m.data;
      end else if (w.wen && (w.rd == rs)) begin
         val = w.data;
      end else begin
         val = rf_data;
      end
      return val;
   endfunction

   assign opa_e = fwd(ex.rs1, rs1_data_e, wb_m, wb_w);
   assign opb_e = fwd(ex.rs2, rs2_data_e, wb_m, wb_w);

   // operand select
   assign alu_a_e = ex.use_pc  ? ex.pc  : opa_e;
   assign alu_b_e = ex.use_imm ? ex.imm : opb_e;

endmodule

/* verilog/ecl_lsu_ctl.sv */
`timescale 1ns/1ps

module ecl_lsu_ctl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ecl_pkg::ex_s                ex,
   input  logic [ecl_pkg::GRLEN-1:0]   opa_e,
   input  logic [ecl_pkg::GRLEN-1:0]   opb_e,
   input  logic                        finish,
   output ecl_pkg::lsu_req_s           lsu_req,
   output logic                        stall_req
);

   logic pending_q;

   always_comb begin
      lsu_req.valid  = ex.lsu_valid;
      lsu_req.op     = ex.lsu_op;
      lsu_req.base   = opa_e;
      lsu_req.offset = ex.imm;
      lsu_req.wdata  = opb_e;
      lsu_req.rd     = ex.rd;
      // only loads come back with a register write
      lsu_req.wen    = ex.rf_wen && (ex.lsu_op == ecl_pkg::LSU_LD_W);
   end

   // outstanding access, held through the finish cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending_q <= 1'b0;
      end else if (lsu_req.valid) begin
         pending_q <= 1'b1;
      end else if (finish) begin
         pending_q <= 1'b0;
      end
   end

   assign stall_req = lsu_req.valid || pending_q;

endmodule

/* verilog/ecl_writeback.sv */
`timescale 1ns/1ps

module ecl_writeback (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ecl_pkg::ex_s                ex,
   input  logic [ecl_pkg::GRLEN-1:0]   alu_res_e,
   input  ecl_pkg::lsu_resp_s          lsu_resp,
   input  logic [ecl_pkg::GRLEN-1:0]   rs1_data_d,
   input  logic [ecl_pkg::GRLEN-1:0]   rs2_data_d,
   output logic [ecl_pkg::GRLEN-1:0]   rs1_data_e,
   output logic [ecl_pkg::GRLEN-1:0]   rs2_data_e,
   output ecl_pkg::wb_s                wb_m,
   output ecl_pkg::wb_s                wb
);

   logic                      alu_wen_m;
   logic [4:0]                alu_rd_m;
   logic [ecl_pkg::GRLEN-1:0] alu_res_m;
   logic                      wen_w;
   logic [4:0]                rd_w;
   logic [ecl_pkg::GRLEN-1:0] data_w;

   // register file data for the execute stage
   always_ff @(posedge clk) begin
      rs1_data_e <= rs1_data_d;
      rs2_data_e <= rs2_data_d;
   end

   //////////////////////////////////////////////////
   // execute to memory
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= ex.alu_valid && ex.rf_wen;
      end
   end

   always_ff @(posedge clk) begin
      alu_rd_m  <= ex.rd;
      alu_res_m <= alu_res_e;
   end

   // a finishing load owns the port
   always_comb begin
      if (lsu_resp.finish) begin
         wb_m.wen  = lsu_resp.wen;
         wb_m.rd   = lsu_resp.rd;
         wb_m.data = lsu_resp.rdata;
      end else begin
         wb_m.wen  = alu_wen_m;
         wb_m.rd   = alu_rd_m;
         wb_m.data = alu_res_m;
      end
   end

   //////////////////////////////////////////////////
   // memory to writeback
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wb_m.wen;
      end
   end

   always_ff @(posedge clk) begin
      rd_w   <= wb_m.rd;
      data_w <= wb_m.data;
   end

   assign wb = '{wen: wen_w, rd: rd_w, data: data_w};

endmodule

/* verilog/exu_ecl.sv */
`timescale 1ns/1ps

module exu_ecl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  ecl_pkg::issue_s             issue,
   input  logic [ecl_pkg::GRLEN-1:0]   rs1_data_d,
   input  logic [ecl_pkg::GRLEN-1:0]   rs2_data_d,
   input  logic [ecl_pkg::GRLEN-1:0]   alu_res_e,
   input  ecl_pkg::lsu_resp_s          lsu_resp,
   output logic [4:0]                  rs1_d,
   output logic [4:0]                  rs2_d,
   output logic [ecl_pkg::GRLEN-1:0]   alu_a_e,
   output logic [ecl_pkg::GRLEN-1:0]   alu_b_e,
   output ecl_pkg::alu_op_e            alu_op_e,
   output ecl_pkg::lsu_req_s           lsu_req,
   output ecl_pkg::wb_s                wb,
   output logic                        stall_req,
   output logic                        except
);

   ecl_pkg::ex_s               ex;
   ecl_pkg::wb_s               wb_m;
   logic [ecl_pkg::GRLEN-1:0]  rs1_data_e;
   logic [ecl_pkg::GRLEN-1:0]  rs2_data_e;
   logic [ecl_pkg::GRLEN-1:0]  opa_e;
   logic [ecl_pkg::GRLEN-1:0]  opb_e;

   assign alu_op_e = ex.alu_op;

   ecl_issue u_issue (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .stall_req (stall_req),
      .rs1_d     (rs1_d),
      .rs2_d     (rs2_d),
      .ex        (ex),
      .except    (except)
   );

   // ALU path
   ecl_bypass u_bypass (
      .ex         (ex),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .wb_m       (wb_m),
      .wb_w       (wb),
      .opa_e      (opa_e),
      .opb_e      (opb_e),
      .alu_a_e    (alu_a_e),
      .alu_b_e    (alu_b_e)
   );

   // memory path
   ecl_lsu_ctl u_lsu_ctl (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex        (ex),
      .opa_e     (opa_e),
      .opb_e     (opb_e),
      .finish    (lsu_resp.finish),
      .lsu_req   (lsu_req),
      .stall_req (stall_req)
   );

   ecl_writeback u_writeback (
      .clk        (clk),
      .rst_n      (rst_n),
      .ex         (ex),
      .alu_res_e  (alu_res_e),
      .lsu_resp   (lsu_resp),
      .rs1_data_d (rs1_data_d),
      .rs2_data_d (rs2_data_d),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .wb_m       (wb_m),
      .wb         (wb)
   );

endmodule

/* tests/exu_ecl_sva.sv */
`timescale 1ns/1ps

module exu_ecl_sva (
   input logic clk,
   input logic rst_n,
   input logic stall_req,
   input logic except,
   input logic wb_wen,
   input logic lsu_valid
);

   // control outputs come out of reset quiet
   a_reset_quiet : assert property (@(posedge clk)
      !rst_n |=> (!stall_req && !except && !wb_wen && !lsu_valid))
      else $error("control outputs not low after reset");

   // exception is a single cycle pulse
   a_except_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      except |=> !except)
      else $error("except held high for two cycles");

   // fetch stays stalled after a request and execute holds a bubble
   a_req_stalls : assert property (@(posedge clk) disable iff (!rst_n)
      lsu_valid |=> (stall_req && !lsu_valid))
      else $error("lsu request not followed by a stalled bubble cycle");

endmodule

bind exu_ecl exu_ecl_sva u_sva (
   .clk       (clk),
   .rst_n     (rst_n),
   .stall_req (stall_req),
   .except    (except),
   .wb_wen    (wb.wen),
   .lsu_valid (lsu_req.valid)
);

/* tests/exu_ecl_tb.sv */
`timescale 1ns/1ps

module exu_ecl_tb;

   localparam int NROWS = 18;
   localparam int LIMIT = 20 * NROWS + 50;
   localparam logic [31:0] LD_KEY = 32'ha5a5_0f0f;

   typedef struct {
      ecl_pkg::unit_e unit;
      logic [2:0]     op;
      logic [4:0]     rd;
      logic [4:0]     rj;
      logic [4:0]     rk;
      logic [31:0]    imm;
      logic           use_pc;
      logic           use_imm;
      logic           rf_wen;
      int             lat;
      logic           kill;
   } row_t;

   typedef struct packed {
      logic [4:0]  rd;
      logic [31:0] data;
   } wr_t;

   typedef struct packed {
      logic [31:0] base;
      logic [31:0] wdata;
   } st_t;

   logic                 clk;
   logic                 rst_n;
   ecl_pkg::issue_s      issue;
   logic [31:0]          rs1_data_d;
   logic [31:0]          rs2_data_d;
   logic [31:0]          alu_res_e;
   ecl_pkg::lsu_resp_s   lsu_resp = '0;
   logic [4:0]           rs1_d;
   logic [4:0]           rs2_d;
   logic [31:0]          alu_a_e;
   logic [31:0]          alu_b_e;
   ecl_pkg::alu_op_e     alu_op_e;
   ecl_pkg::lsu_req_s    lsu_req;
   ecl_pkg::wb_s         wb;
   logic                 stall_req;
   logic                 except;

   row_t        tbl [NROWS];
   int          nrows;
   logic [31:0] rf [32];
   logic [31:0] rf_init [32];
   logic [31:0] ref_rf [32];
   logic [31:0] mem [64];
   wr_t         exp_q[$];
   st_t         st_q[$];
   int          cur_lat = 1;
   int          cycles = 0;
   logic        lsu_busy;
   int          lsu_cnt;
   logic [4:0]  lsu_rd;
   logic        lsu_wen;
   logic [31:0] lsu_addr;

   exu_ecl UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .rs1_data_d (rs1_data_d),
      .rs2_data_d (rs2_data_d),
      .alu_res_e  (alu_res_e),
      .lsu_resp   (lsu_resp),
      .rs1_d      (rs1_d),
      .rs2_d      (rs2_d),
      .alu_a_e    (alu_a_e),
      .alu_b_e    (alu_b_e),
      .alu_op_e   (alu_op_e),
      .lsu_req    (lsu_req),
      .wb         (wb),
      .stall_req  (stall_req),
      .except     (except)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
                                             input ecl_pkg::alu_op_e op);
      case (op)
         ecl_pkg::ALU_ADD: return a + b;
         ecl_pkg::ALU_SUB: return a - b;
         ecl_pkg::ALU_AND: return a & b;
         ecl_pkg::ALU_OR:  return a | b;
         ecl_pkg::ALU_XOR: return a ^ b;
         ecl_pkg::ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
         default:          return 32'd0;
      endcase
   endfunction

   function automatic logic [31:0] pc_of(input int idx);
      return 32'h1c00_0000 + (32'(idx) << 2);
   endfunction

   function automatic ecl_pkg::issue_s make_issue(input int idx);
      ecl_pkg::issue_s s;
      s         = '0;
      s.valid   = 1'b1;
      s.unit    = tbl[idx].unit;
      s.alu_op  = ecl_pkg::alu_op_e'(tbl[idx].op);
      s.lsu_op  = ecl_pkg::lsu_op_e'(tbl[idx].op[0]);
      s.inst    = {17'd0, tbl[idx].rk, tbl[idx].rj, tbl[idx].rd};
      s.pc      = pc_of(idx);
      s.imm     = tbl[idx].imm;
      s.use_pc  = tbl[idx].use_pc;
      s.use_imm = tbl[idx].use_imm;
      s.rf_wen  = tbl[idx].rf_wen;
      return s;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic add_row(input ecl_pkg::unit_e unit, input logic [2:0] op,
                          input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk,
                          input logic [31:0] imm, input logic use_pc, input logic use_imm,
                          input logic rf_wen, input int lat, input logic kill);
      tbl[nrows] = '{unit, op, rd, rj, rk, imm, use_pc, use_imm, rf_wen, lat, kill};
      nrows++;
   endtask

   //////////////////////////////////////////////////
   // register file, alu and lsu models
   //////////////////////////////////////////////////

   // write-first read ports
   assign rs1_data_d = (wb.wen && wb.rd == rs1_d) ? wb.data : rf[rs1_d];
   assign rs2_data_d = (wb.wen && wb.rd == rs2_d) ? wb.data : rf[rs2_d];
   assign alu_res_e  = alu_model(alu_a_e, alu_b_e, alu_op_e);

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            rf[i] <= rf_init[i];
         end
      end else if (wb.wen) begin
         rf[wb.rd] <= wb.data;
      end
   end

   always @(posedge clk) begin : lsu_model
      st_t         s;
      logic [31:0] addr;
      if (!rst_n) begin
         lsu_resp <= '0;
         lsu_busy <= 1'b0;
         lsu_cnt  <= 0;
      end else begin
         // fetch stalls from the request through the finish cycle
         check({31'd0, stall_req}, {31'd0, lsu_req.valid || lsu_busy || lsu_resp.finish},
               "fetch stall");
         lsu_resp.finish <= 1'b0;
         if (lsu_busy) begin
            if (lsu_cnt == 1) begin
               lsu_resp.finish <= 1'b1;
               lsu_resp.rd     <= lsu_rd;
               lsu_resp.wen    <= lsu_wen;
               lsu_resp.rdata  <= lsu_addr ^ LD_KEY;
               lsu_busy        <= 1'b0;
            end else begin
               lsu_cnt <= lsu_cnt - 1;
            end
         end
         if (lsu_req.valid) begin
            addr = lsu_req.base + lsu_req.offset;
            lsu_busy <= 1'b1;
            lsu_cnt  <= cur_lat;
            lsu_rd   <= lsu_req.rd;
            lsu_wen  <= lsu_req.wen;
            lsu_addr <= addr;
            if (lsu_req.op == ecl_pkg::LSU_ST_W) begin
               if (st_q.size() == 0) begin
                  $display("store request arrived that no table row expects");
                  $display("RESULT: FAIL");
                  $fatal(1, "unexpected store");
               end else begin
                  s = st_q.pop_front();
                  check(lsu_req.base, s.base, "store base");
                  check(lsu_req.wdata, s.wdata, "store data");
                  mem[addr[7:2]] <= lsu_req.wdata;
               end
            end
         end
      end
   end

   // every write is compared in order
   always @(posedge clk) begin : wb_check
      wr_t w;
      if (rst_n && wb.wen) begin
         if (exp_q.size() == 0) begin
            $display("register write to r%0d that no table row expects", wb.rd);
            $display("RESULT: FAIL");
            $fatal(1, "unexpected write");
         end else begin
            w = exp_q.pop_front();
            check({27'd0, wb.rd}, {27'd0, w.rd}, "write address");
            check(wb.data, w.data, "write data");
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout after %0d cycles with writes still missing", cycles);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////
   // stimulus and reference model
   //////////////////////////////////////////////////

   task automatic fill_table();
      nrows = 0;
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd1,  5'd2,  5'd3,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd1, 5'd4,  5'd1,  5'd5,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd4, 5'd6,  5'd7,  5'd0,  32'h0ff, 0, 1, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd2, 5'd8,  5'd1,  5'd4,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd3, 5'd9,  5'd0,  5'd0,  32'h30,  1, 1, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd1,  5'd9,  5'd6,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd5, 5'd10, 5'd1,  5'd8,  32'h0,   0, 0, 1, 1, 0);
      // two writes to r10, memory stage must win
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd10, 5'd10, 5'd1,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd11, 5'd10, 5'd10, 32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_LSU, 3'd1, 5'd10, 5'd11, 5'd0,  32'h10,  0, 0, 1, 2, 0);
      add_row(ecl_pkg::UNIT_LSU, 3'd0, 5'd12, 5'd1,  5'd0,  32'h20,  0, 0, 1, 3, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd13, 5'd12, 5'd12, 32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_LSU, 3'd0, 5'd14, 5'd13, 5'd0,  32'h4,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ILL, 3'd0, 5'd15, 5'd1,  5'd2,  32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd16, 5'd1,  5'd2,  32'h0,   0, 0, 1, 1, 1);
      add_row(ecl_pkg::UNIT_ALU, 3'd0, 5'd17, 5'd14, 5'd16, 32'h0,   0, 0, 1, 1, 0);
      add_row(ecl_pkg::UNIT_LSU, 3'd1, 5'd14, 5'd17, 5'd0,  32'h8,   0, 0, 0, 1, 0);
      add_row(ecl_pkg::UNIT_ALU, 3'd4, 5'd18, 5'd17, 5'd14, 32'h0,   0, 0, 1, 1, 0);
   endtask

   // sequential execution of the table gives the architectural results
   task automatic build_expected();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      for (int i = 0; i < NROWS; i++) begin
         if (tbl[i].kill || tbl[i].unit == ecl_pkg::UNIT_ILL) begin
            continue;
         end
         if (tbl[i].unit == ecl_pkg::UNIT_ALU) begin
            a   = tbl[i].use_pc  ? pc_of(i)    : ref_rf[tbl[i].rj];
            b   = tbl[i].use_imm ? tbl[i].imm  : ref_rf[tbl[i].rk];
            res = alu_model(a, b, ecl_pkg::alu_op_e'(tbl[i].op));
            if (tbl[i].rf_wen) begin
               exp_q.push_back('{tbl[i].rd, res});
               ref_rf[tbl[i].rd] = res;
            end
         end else if (tbl[i].op[0] == 1'b0) begin
            res = (ref_rf[tbl[i].rj] + tbl[i].imm) ^ LD_KEY;
            if (tbl[i].rf_wen) begin
               exp_q.push_back('{tbl[i].rd, res});
               ref_rf[tbl[i].rd] = res;
            end
         end else begin
            st_q.push_back('{ref_rf[tbl[i].rj], ref_rf[tbl[i].rd]});
         end
      end
   endtask

   initial begin : main
      logic [31:0] state;
      logic [31:0] v;
      rst_n <= 1'b0;
      issue <= '0;
      state = 32'd46;
      v     = '0;
      for (int i = 0; i < 32; i++) begin
         for (int k = 0; k < 32; k++) begin
            state = lfsr_next(state);
            v     = {v[30:0], state[0]};
         end
         rf_init[i] = v;
         ref_rf[i]  = v;
      end
      fill_table();
      build_expected();

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < NROWS; i++) begin
         @(posedge clk);
         issue <= make_issue(i);
         @(negedge clk);
         // held while fetch is stalled
         while (stall_req) begin
            @(negedge clk);
         end
         check({31'd0, except}, {31'd0, tbl[i].kill}, $sformatf("except for row %0d", i));
         if (tbl[i].unit == ecl_pkg::UNIT_LSU) begin
            cur_lat = tbl[i].lat;
         end
      end
      @(posedge clk);
      issue <= '0;

      while (exp_q.size() != 0 || st_q.size() != 0 || stall_req) begin
         @(posedge clk);
      end
      // catch stray writes
      repeat (6) @(posedge clk);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* exu_ecl.f */
verilog/ecl_pkg.sv
verilog/ecl_issue.sv
verilog/ecl_bypass.sv
verilog/ecl_lsu_ctl.sv
verilog/ecl_writeback.sv
verilog/exu_ecl.sv
tests/exu_ecl_sva.sv
tests/exu_ecl_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exu_ecl_tb \
   -Mdir obj_dir -f exu_ecl.f

out=$(./obj_dir/Vexu_ecl_tb || true)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"
